/* source/level_maps.svh */
`ifndef LEVEL_MAPS_SVH
`define LEVEL_MAPS_SVH

// cell forced to TILE_GATE while gate is held
localparam tile_row_t GATE_ROW = 3'd6;
localparam tile_col_t GATE_COL = 4'd4;

// indexed [level][row][col] with row 0 at the top of the screen
localparam tile_e LEVEL_MAPS [NUM_LEVELS][NUM_ROWS][NUM_COLS] = '{
	'{
		'{TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,
		  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_WALL},
		'{TILE_REGU,  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_REGU,
		  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_WALL},
		'{TILE_FREE,  TILE_FREE,  TILE_REGU,  TILE_FREE,  TILE_FREE,
		  TILE_FREE,  TILE_DEATH, TILE_FREE,  TILE_FREE,  TILE_WALL},
		'{TILE_FREE,  TILE_REGU,  TILE_FREE,  TILE_REGU,  TILE_FREE,
		  TILE_REGU,  TILE_FREE,  TILE_REGU,  TILE_FREE,  TILE_REGU},
		'{TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,
		  TILE_FREE,  TILE_REGU,  TILE_FREE,  TILE_FREE,  TILE_FREE},
		'{TILE_REGU,  TILE_FREE,  TILE_REGU,  TILE_REGU,  TILE_FREE,
		  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_REGU,  TILE_FREE},
		'{TILE_WALL,  TILE_REGU,  TILE_REGU,  TILE_REGU,  TILE_FREE,
		  TILE_SPIKE, TILE_FREE,  TILE_REGU,  TILE_FREE,  TILE_REGU}
	},
	'{
		'{TILE_WALL,  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,
		  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE},
		'{TILE_WALL,  TILE_FREE,  TILE_FREE,  TILE_DEATH, TILE_FREE,
		  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_REGU,  TILE_FREE},
		'{TILE_WALL,  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,
		  TILE_FREE,  TILE_REGU,  TILE_FREE,  TILE_FREE,  TILE_FREE},
		'{TILE_REGU,  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_REGU,
		  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE},
		'{TILE_FREE,  TILE_FREE,  TILE_REGU,  TILE_FREE,  TILE_FREE,
		  TILE_FREE,  TILE_FREE,  TILE_SPIKE, TILE_FREE,  TILE_FREE},
		'{TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,
		  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_FREE,  TILE_WALL},
		'{TILE_SPIKE, TILE_REGU,  TILE_REGU,  TILE_REGU,  TILE_REGU,
		  TILE_REGU,  TILE_REGU,  TILE_REGU,  TILE_REGU,  TILE_REGU}
	}
};

`endif

/* source/tile_pkg.sv */
`default_nettype none

package tile_pkg;

	// grid geometry in 64 pixel square tiles
	localparam int TILE_SHIFT = 6;
	localparam int NUM_COLS   = 10;
	localparam int NUM_ROWS   = 7;
	localparam int NUM_LEVELS = 2;

	typedef logic [10:0] coord_t;    // pixel x or y
	typedef logic [3:0]  tile_col_t;
	typedef logic [2:0]  tile_row_t;
	typedef logic [5:0]  tile_off_t; // position inside a tile
	typedef logic        level_t;
	typedef logic [7:0]  colour_t;   // rgb332

	typedef enum logic [2:0] {
		TILE_FREE  = 3'd0,
		TILE_REGU  = 3'd1,
		TILE_GATE  = 3'd2,
		TILE_DEATH = 3'd3,
		TILE_WALL  = 3'd4,
		TILE_SPIKE = 3'd5
	} tile_e;

	// 0 left, 1 up, 2 right, 3 down
	typedef tile_e [3:0] tile_area_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pix_req_t;

	typedef struct packed {
		tile_col_t col;
		tile_row_t row;
		tile_off_t off_x;
		tile_off_t off_y;
		logic      in_grid;
	} loc_t;

	typedef struct packed {
		tile_e     tile;
		tile_off_t off_x;
		tile_off_t off_y;
		logic      in_grid;
	} tile_hit_t;

	localparam colour_t BG_COLOUR      = 8'h00; // black outside the grid
	localparam colour_t OUTLINE_COLOUR = 8'h24;
	localparam colour_t FILL_FREE      = 8'h57; // sky
	localparam colour_t FILL_REGU      = 8'hA8; // brown
	localparam colour_t FILL_GATE      = 8'hFC;
	localparam colour_t FILL_DEATH     = 8'hE0;
	localparam colour_t FILL_WALL      = 8'h92;
	localparam colour_t FILL_SPIKE     = 8'hA2;

	`include "level_maps.svh"

endpackage

`default_nettype wire

/* source/grid_locator.sv */
`default_nettype none

module grid_locator
	import tile_pkg::*;
(
	input  logic     clk,
	input  logic     resetN,

	input  logic     in_valid,
	output logic     in_ready,
	input  pix_req_t in_data,

	output logic     loc_valid,
	input  logic     loc_ready,
	output loc_t     loc_data
);

	coord_t col_full; // tile index before narrowing
	coord_t row_full;
	loc_t   loc_next;

	assign col_full = in_data.x >> TILE_SHIFT;
	assign row_full = in_data.y >> TILE_SHIFT;

	always_comb begin
		loc_next.col     = tile_col_t'(col_full);
		loc_next.row     = tile_row_t'(row_full);
		loc_next.off_x   = tile_off_t'(in_data.x); // low six bits
		loc_next.off_y   = tile_off_t'(in_data.y);
		// checked on the wide index so x >= 1024 is not folded back in
		loc_next.in_grid = (col_full < NUM_COLS) && (row_full < NUM_ROWS);
	end

	// register empty or draining this cycle
	assign in_ready = !loc_valid || loc_ready;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			loc_valid <= 1'b0;
		else if (in_ready)
			loc_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			loc_data <= loc_next;
	end

endmodule

`default_nettype wire

/* source/tile_map.sv */
`default_nettype none

module tile_map
	import tile_pkg::*;
(
	input  logic       clk,
	input  logic       resetN,

	input  logic       loc_valid,
	output logic       loc_ready,
	input  loc_t       loc_data,

	output logic       hit_valid,
	input  logic       hit_ready,
	output tile_hit_t  hit_data,

	input  logic       next_lvl, // one cycle pulse
	input  level_t     lvl,
	input  logic       gate,

	input  coord_t     player_x,
	input  coord_t     player_y,
	output tile_area_t area
);

	level_t    lvl_q;  // active level
	logic      gate_q;
	coord_t    p_col;  // player tile position
	coord_t    p_row;
	tile_hit_t hit_next;

	// one lookup path for pixels and for the player neighbours
	// the gate cell is patched on every read and the map itself never changes
	function automatic tile_e read_tile(level_t l, logic g, int col, int row);
		if (col < 0 || col >= NUM_COLS || row < 0 || row >= NUM_ROWS)
			return TILE_WALL; // off the grid counts as solid
		if (g && row == GATE_ROW && col == GATE_COL)
			return TILE_GATE;
		return LEVEL_MAPS[l][row][col];
	endfunction

	function automatic tile_area_t area_at(level_t l, logic g, int col, int row);
		tile_area_t a;

		a[0] = read_tile(l, g, col - 1, row); // left
		a[1] = read_tile(l, g, col, row - 1); // up
		a[2] = read_tile(l, g, col + 1, row); // right
		a[3] = read_tile(l, g, col, row + 1); // down
		return a;
	endfunction

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lvl_q  <= '0;
			gate_q <= 1'b0;
		end
		else begin
			if (next_lvl)
				lvl_q <= lvl;
			gate_q <= gate;
		end
	end

	// pixel path

	always_comb begin
		hit_next.off_x   = loc_data.off_x;
		hit_next.off_y   = loc_data.off_y;
		hit_next.in_grid = loc_data.in_grid;
		// tile is a don't care outside the grid where the shader paints background
		if (loc_data.in_grid)
			hit_next.tile = read_tile(lvl_q, gate_q, int'(loc_data.col), int'(loc_data.row));
		else
			hit_next.tile = TILE_FREE;
	end

	assign loc_ready = !hit_valid || hit_ready;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			hit_valid <= 1'b0;
		else if (loc_ready)
			hit_valid <= loc_valid;
	end

	always_ff @(posedge clk) begin
		if (loc_valid && loc_ready)
			hit_data <= hit_next;
	end

	// player neighbours refreshed every cycle

	assign p_col = player_x >> TILE_SHIFT;
	assign p_row = player_y >> TILE_SHIFT;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			area <= area_at(level_t'(0), 1'b0, 0, 0); // level 0 around the origin
		else
			area <= area_at(lvl_q, gate_q, int'(p_col), int'(p_row));
	end

endmodule

`default_nettype wire

/* source/tile_shader.sv */
`default_nettype none

module tile_shader
	import tile_pkg::*;
(
	input  logic      clk,
	input  logic      resetN,

	input  logic      hit_valid,
	output logic      hit_ready,
	input  tile_hit_t hit_data,

	output logic      out_valid,
	input  logic      out_ready,
	output colour_t   out_colour
);

	colour_t colour_next;

	function automatic colour_t fill_of(tile_e t);
		case (t)
			TILE_FREE:  return FILL_FREE;
			TILE_REGU:  return FILL_REGU;
			TILE_GATE:  return FILL_GATE;
			TILE_DEATH: return FILL_DEATH;
			TILE_WALL:  return FILL_WALL;
			TILE_SPIKE: return FILL_SPIKE;
			default:    return BG_COLOUR; // codes 6 and 7 never stored
		endcase
	endfunction

	always_comb begin
		if (!hit_data.in_grid)
			colour_next = BG_COLOUR;
		else if (hit_data.tile != TILE_FREE &&
				(hit_data.off_x == '0 || hit_data.off_y == '0))
			colour_next = OUTLINE_COLOUR; // top and left edge line
		else
			colour_next = fill_of(hit_data.tile);
	end

	assign hit_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			out_valid <= 1'b0;
		else if (hit_ready)
			out_valid <= hit_valid;
	end

	always_ff @(posedge clk) begin
		if (hit_valid && hit_ready)
			out_colour <= colour_next;
	end

endmodule

`default_nettype wire

/* source/tile_pipeline_top.sv */
`default_nettype none

module tile_pipeline_top
	import tile_pkg::*;
(
	input  logic       clk,
	input  logic       resetN,

	input  logic       in_valid,
	output logic       in_ready,
	input  pix_req_t   in_data,

	output logic       out_valid,
	input  logic       out_ready,
	output colour_t    out_colour,

	input  logic       next_lvl,
	input  level_t     lvl,
	input  logic       gate,

	input  coord_t     player_x,
	input  coord_t     player_y,
	output tile_area_t area
);

	logic      loc_valid;  // locator to map
	logic      loc_ready;
	loc_t      loc_data;
	logic      hit_valid;  // map to shader
	logic      hit_ready;
	tile_hit_t hit_data;

	grid_locator u_locator (
		.clk       (clk),
		.resetN    (resetN),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.loc_valid (loc_valid),
		.loc_ready (loc_ready),
		.loc_data  (loc_data)
	);

	tile_map u_map (
		.clk       (clk),
		.resetN    (resetN),
		.loc_valid (loc_valid),
		.loc_ready (loc_ready),
		.loc_data  (loc_data),
		.hit_valid (hit_valid),
		.hit_ready (hit_ready),
		.hit_data  (hit_data),
		.next_lvl  (next_lvl),
		.lvl       (lvl),
		.gate      (gate),
		.player_x  (player_x),
		.player_y  (player_y),
		.area      (area)
	);

	tile_shader u_shader (
		.clk        (clk),
		.resetN     (resetN),
		.hit_valid  (hit_valid),
		.hit_ready  (hit_ready),
		.hit_data   (hit_data),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_colour (out_colour)
	);

endmodule

`default_nettype wire

/* dv/tile_pipeline_tb.sv */
`default_nettype none

module tile_pipeline_tb
	import tile_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD   = 8;
	localparam int N_RAND       = 200;
	localparam int N_SHORT      = 40;
	localparam int N_BP         = 300;
	localparam int TOTAL_BEATS  = 2 * N_RAND + 5 * N_SHORT + N_BP;
	localparam int STALL_FACTOR = 4;
	localparam int MARGIN_NS    = 10000; // player sweeps and idle gaps

	logic       clk = 1'b0;
	logic       resetN;
	logic       in_valid, in_ready, out_valid, out_ready;
	pix_req_t   in_data;
	colour_t    out_colour;
	logic       next_lvl, gate, stall_en;
	level_t     lvl, mlvl;
	coord_t     player_x, player_y;
	tile_area_t area, exp_area;
	logic       mgate;
	logic [31:0] stim_lfsr  = 32'hcb87;
	logic [31:0] stall_lfsr = 32'hcb87;
	pix_req_t   beat_q[$];  // beats waiting to be driven
	colour_t    exp_q[$];   // colours of accepted beats, oldest first
	int         mismatch_count = 0;
	int         fail_count = 0;
	string      test_name = "reset";

	tile_pipeline_top dut0 (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
	endtask

	// tile at a cell with walls all around the grid
	function automatic tile_e cell_ref(level_t l, logic g, int c, int r);
		if (c < 0 || c >= NUM_COLS || r < 0 || r >= NUM_ROWS)
			return TILE_WALL;
		if (g && c == int'(GATE_COL) && r == int'(GATE_ROW))
			return TILE_GATE;
		return LEVEL_MAPS[l][r][c];
	endfunction

	function automatic colour_t colour_ref(level_t l, logic g, coord_t x, coord_t y);
		tile_e t;
		if (x >= NUM_COLS * 64 || y >= NUM_ROWS * 64)
			return BG_COLOUR;
		t = cell_ref(l, g, int'(x / 64), int'(y / 64));
		if (t != TILE_FREE && (x % 64 == 0 || y % 64 == 0))
			return OUTLINE_COLOUR;
		case (t)
			TILE_FREE:  return FILL_FREE;
			TILE_REGU:  return FILL_REGU;
			TILE_GATE:  return FILL_GATE;
			TILE_DEATH: return FILL_DEATH;
			TILE_WALL:  return FILL_WALL;
			TILE_SPIKE: return FILL_SPIKE;
			default:    return BG_COLOUR;
		endcase
	endfunction

	function automatic tile_area_t area_ref(level_t l, logic g, coord_t px, coord_t py);
		int c, r;
		tile_area_t a;
		c = int'(px / 64);
		r = int'(py / 64);
		a[0] = cell_ref(l, g, c - 1, r);
		a[1] = cell_ref(l, g, c, r - 1);
		a[2] = cell_ref(l, g, c + 1, r);
		a[3] = cell_ref(l, g, c, r + 1);
		return a;
	endfunction

	// level, gate and area as the DUT should hold them
	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			mlvl     <= '0;
			mgate    <= 1'b0;
			exp_area <= area_ref(level_t'(0), 1'b0, '0, '0);
		end
		else begin
			if (next_lvl)
				mlvl <= lvl;
			mgate    <= gate;
			exp_area <= area_ref(mlvl, mgate, player_x, player_y);
		end
	end

	// input driver and out_ready stalls
	always @(posedge clk) begin
		if (!resetN) begin
			in_valid  <= 1'b0;
			out_ready <= 1'b1;
		end
		else begin
			if (stall_en) begin
				stall_lfsr = lfsr_next(stall_lfsr);
				out_ready <= stall_lfsr[0];
			end
			else
				out_ready <= 1'b1;
			if (!in_valid || in_ready) begin
				if (beat_q.size() > 0) begin
					in_data  <= beat_q.pop_front();
					in_valid <= 1'b1;
				end
				else
					in_valid <= 1'b0;
			end
		end
	end

	// scoreboard pops the output before pushing the input
	always @(posedge clk) begin
		colour_t want;
		if (resetN) begin
			if (out_valid && out_ready) begin
				assert (exp_q.size() != 0) else begin
					fail_count++;
					$display("%s: output beat appeared with no input beat pending", test_name);
				end
				if (exp_q.size() != 0) begin
					want = exp_q.pop_front();
					assert (out_colour == want) else begin
						mismatch_count++;
						$display("MISMATCH %s expected %h actual %h", test_name, want, out_colour);
					end
				end
			end
			if (in_valid && in_ready)
				exp_q.push_back(colour_ref(mlvl, mgate, in_data.x, in_data.y));
		end
	end

	area_check: assert property (@(posedge clk) disable iff (!resetN) area == exp_area)
		else begin
			mismatch_count++;
			$display("MISMATCH %s expected %h actual %h", test_name, $sampled(exp_area),
				$sampled(area));
		end

	hold_check: assert property (@(posedge clk) disable iff (!resetN)
			out_valid && !out_ready |=> out_valid && $stable(out_colour))
		else begin
			fail_count++;
			$display("%s: output beat dropped or changed while stalled", test_name);
		end

	task automatic wait_drain();
		do
			@(posedge clk);
		while (beat_q.size() != 0 || in_valid || exp_q.size() != 0);
	endtask

	// in_grid set for pixels inside the grid and clear for pixels past the right or bottom edge
	task automatic run_pixels(input int n, input bit in_grid);
		logic [31:0] bx, by;
		pix_req_t p;
		for (int i = 0; i < n; i++) begin
			take_bits(11, bx);
			take_bits(11, by);
			if (in_grid) begin
				p.x = coord_t'(bx % 640);
				p.y = coord_t'(by % 448);
				if (i % 8 == 0)
					p.x[5:0] = '0; // left outline column
				if (i % 8 == 4)
					p.y[5:0] = '0;
			end
			else begin
				p.x = (i % 2) ? coord_t'(640 + bx % 1400) : coord_t'(bx % 640);
				p.y = (i % 2) ? coord_t'(by) : coord_t'(448 + by % 1600);
			end
			beat_q.push_back(p);
		end
		wait_drain();
	endtask

	task automatic run_gate_cell(input int n);
		logic [31:0] b;
		pix_req_t p;
		for (int i = 0; i < n; i++) begin
			take_bits(12, b);
			p.x = coord_t'(GATE_COL) * 64 + coord_t'(b[5:0]);
			p.y = coord_t'(GATE_ROW) * 64 + coord_t'(b[11:6]);
			beat_q.push_back(p);
		end
		wait_drain();
	endtask

	task automatic place_player(input int x, input int y);
		@(posedge clk);
		player_x <= coord_t'(x);
		player_y <= coord_t'(y);
		repeat (2) @(posedge clk);
	endtask

	task automatic sweep_player();
		for (int r = 0; r < NUM_ROWS; r++)
			for (int c = 0; c < NUM_COLS; c++)
				place_player(c * 64 + 32, r * 64 + 17);
		place_player(700, 100); // just right of the grid
		place_player(100, 500); // just below it
	endtask

	task automatic load_level(input level_t l);
		@(posedge clk);
		next_lvl <= 1'b1;
		lvl      <= l;
		@(posedge clk);
		next_lvl <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic set_gate(input logic g);
		@(posedge clk);
		gate <= g;
		repeat (2) @(posedge clk);
	endtask

	task automatic gate_phase(input logic g, input string name);
		set_gate(g);
		test_name = name;
		run_gate_cell(N_SHORT);
		place_player(4 * 64 + 10, 5 * 64 + 10); // gate cell below
		place_player(3 * 64 + 10, 6 * 64 + 10); // gate cell to the right
		place_player(5 * 64 + 10, 6 * 64 + 10); // gate cell to the left
	endtask

	initial begin
		resetN   = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		out_ready = 1'b1;
		next_lvl = 1'b0;
		lvl      = '0;
		gate     = 1'b0;
		player_x = '0;
		player_y = '0;
		stall_en = 1'b0;
		repeat (4) @(posedge clk);
		resetN <= 1'b1;
		@(posedge clk);
		assert (in_ready && !out_valid) else begin
			fail_count++;
			$display("in_ready low or out_valid high after reset");
		end
		test_name = "level0_colours";
		run_pixels(N_RAND, 1'b1);
		test_name = "background";
		run_pixels(N_SHORT, 1'b0);
		test_name = "level0_area";
		sweep_player();
		load_level(level_t'(1));
		test_name = "level1";
		run_pixels(N_RAND, 1'b1);
		sweep_player();
		load_level(level_t'(0));
		test_name = "level0_reload";
		run_pixels(N_SHORT, 1'b1);
		gate_phase(1'b1, "gate_on");
		gate_phase(1'b0, "gate_off");
		test_name = "back_pressure";
		@(posedge clk);
		stall_en <= 1'b1;
		run_pixels(N_BP, 1'b1);
		run_pixels(N_SHORT, 1'b0);
		@(posedge clk);
		stall_en <= 1'b0;
		repeat (4) @(posedge clk);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// watchdog
	initial begin
		#(TOTAL_BEATS * CLK_PERIOD * STALL_FACTOR + MARGIN_NS);
		$display("timeout in %s with %0d expected colours still pending", test_name,
			exp_q.size());
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/tile_pkg.sv
source/grid_locator.sv
source/tile_map.sv
source/tile_shader.sv
source/tile_pipeline_top.sv
dv/tile_pipeline_tb.sv

/* Bender.yml */
package:
  name: tile_pipeline

sources:
  - include_dirs:
      - source
    files:
      - source/tile_pkg.sv
      - source/grid_locator.sv
      - source/tile_map.sv
      - source/tile_shader.sv
      - source/tile_pipeline_top.sv
  - target: test
    files:
      - dv/tile_pipeline_tb.sv
